// File: common/rd_conv_pkg.sv
package rd_conv_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Bus geometry
   ////////////////////////////////////////////////////////////////////////////

   // Byte lanes on the narrow slave read bus
   localparam int SLV_BYTES = 4;

   // Byte lanes on the wide master read bus
   localparam int MST_BYTES = 16;

   // Byte address within one master word
   localparam int LANE_ADDR_W = 4;

   // Command queue
   localparam int CMD_DEPTH = 4;
   localparam int CMD_PTR_W = $clog2(CMD_DEPTH);

   ////////////////////////////////////////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////////////////////////////////////////

   // Coded as log2 of the byte count
   typedef enum logic [1:0]
   {
      SIZE_1B = 2'd0,
      SIZE_2B = 2'd1,
      SIZE_4B = 2'd2
   } beat_size_e;

   // AXI read response where a higher code is worse
   typedef enum logic [1:0]
   {
      OKAY   = 2'd0,
      EXOKAY = 2'd1,
      SLVERR = 2'd2,
      DECERR = 2'd3
   } resp_e;

   ////////////////////////////////////////////////////////////////////////////
   // Transfers
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed
   {
      logic [LANE_ADDR_W-1:0] start_addr;
      beat_size_e             size;
   } rd_cmd_t;

   typedef struct packed
   {
      logic [SLV_BYTES*8-1:0] data;
      resp_e                  resp;
      logic                   last;
   } slv_beat_t;

   typedef struct packed
   {
      logic [MST_BYTES*8-1:0] data;
      resp_e                  resp;
      logic                   last;
   } mst_beat_t;

endpackage

// File: src/rd_cmd_fifo.sv
module rd_cmd_fifo
(
   input  logic                 ACLK,
   input  logic                 sysReset,
   input  logic                 cmd_wr,
   input  rd_conv_pkg::rd_cmd_t cmd_in,
   input  logic                 cmd_pop,
   output rd_conv_pkg::rd_cmd_t cmd_head,
   output logic                 cmd_empty,
   output logic                 cmd_full
);

   rd_conv_pkg::rd_cmd_t mem [rd_conv_pkg::CMD_DEPTH];

   logic [rd_conv_pkg::CMD_PTR_W-1:0] wr_ptr;
   logic [rd_conv_pkg::CMD_PTR_W-1:0] rd_ptr;
   logic [rd_conv_pkg::CMD_PTR_W:0]   count;

   // Entry storage
   always_ff @(posedge ACLK)
   begin
      if (cmd_wr)
      begin
         mem[wr_ptr] <= cmd_in;
      end
   end

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (cmd_wr)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (cmd_pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous write and pop leave the level unchanged
         if (cmd_wr && !cmd_pop)
         begin
            count <= count + 1'b1;
         end
         else if (cmd_pop && !cmd_wr)
         begin
            count <= count - 1'b1;
         end
      end
   end

   assign cmd_head  = mem[rd_ptr];
   assign cmd_empty = (count == '0);
   assign cmd_full  = (count == (rd_conv_pkg::CMD_PTR_W + 1)'(rd_conv_pkg::CMD_DEPTH));

   ////////////////////////////////////////////////////////////////////////////
   // Queue usage rules
   ////////////////////////////////////////////////////////////////////////////

   a_no_write_when_full : assert property (
      @(posedge ACLK) disable iff (!sysReset)
      cmd_full |-> !cmd_wr
   ) else $error("command written while queue full");

   a_no_pop_when_empty : assert property (
      @(posedge ACLK) disable iff (!sysReset)
      cmd_empty |-> !cmd_pop
   ) else $error("command popped while queue empty");

endmodule

// File: rd_pack/rd_pack_ctrl.sv
module rd_pack_ctrl
(
   input  logic ACLK,
   input  logic sysReset,
   input  logic cmd_empty,
   input  logic slave_valid,
   input  logic slave_last,
   input  logic word_end,
   input  logic master_ready,
   output logic slave_ready,
   output logic slave_fire,
   output logic cmd_pop,
   output logic master_load,
   output logic master_valid,
   output logic master_last,
   output logic first_beat
);

   logic hold;

   // Master has a beat it has not taken yet
   assign hold = master_valid & ~master_ready;

   assign slave_ready = ~cmd_empty & ~hold;
   assign slave_fire  = slave_valid & slave_ready;

   // Command retires with its final slave beat
   assign cmd_pop = slave_fire & slave_last;

   // A master beat leaves when the word fills up or the burst ends
   assign master_load = slave_fire & (word_end | slave_last);

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         master_valid <= 1'b0;
         master_last  <= 1'b0;
      end
      else
      begin
         if (master_load)
         begin
            master_valid <= 1'b1;
            master_last  <= slave_last;
         end
         else if (master_ready)
         begin
            master_valid <= 1'b0;
         end
      end
   end

   // Set again once the current command has seen its last beat
   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         first_beat <= 1'b1;
      end
      else if (slave_fire)
      begin
         first_beat <= slave_last;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Back-pressure
   ////////////////////////////////////////////////////////////////////////////

   a_hold_stable : assert property (
      @(posedge ACLK) disable iff (!sysReset)
      (hold ##1 hold) |-> $stable({master_valid, master_last, slave_ready})
   ) else $error("handshake state changed during hold");

endmodule

// File: rd_pack/rd_lane_pos.sv
module rd_lane_pos
(
   input  logic                                ACLK,
   input  logic                                sysReset,
   input  rd_conv_pkg::rd_cmd_t                cmd_head,
   input  logic                                first_beat,
   input  logic                                slave_fire,
   output logic [rd_conv_pkg::LANE_ADDR_W-1:0] lane_addr,
   output logic                                word_end
);

   logic [rd_conv_pkg::LANE_ADDR_W-1:0] addr_q;
   logic [rd_conv_pkg::LANE_ADDR_W-1:0] beat_bytes;
   logic [rd_conv_pkg::LANE_ADDR_W-1:0] start_aligned;
   logic [rd_conv_pkg::LANE_ADDR_W:0]   next_sum;

   assign beat_bytes = rd_conv_pkg::LANE_ADDR_W'(1) << cmd_head.size;

   // Drop the low address bits below the beat size
   assign start_aligned = cmd_head.start_addr & ~(beat_bytes - 1'b1);

   assign lane_addr = first_beat ? start_aligned : addr_q;

   // Carry out means this beat reaches lane 15
   assign next_sum = {1'b0, lane_addr} + {1'b0, beat_bytes};
   assign word_end = next_sum[rd_conv_pkg::LANE_ADDR_W];

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         addr_q <= '0;
      end
      else if (slave_fire)
      begin
         // Wraps at 16 by truncation
         addr_q <= next_sum[rd_conv_pkg::LANE_ADDR_W-1:0];
      end
   end

endmodule

// File: rd_pack/rd_data_pack.sv
module rd_data_pack
(
   input  logic                                  ACLK,
   input  logic                                  sysReset,
   input  logic                                  slave_fire,
   input  logic                                  master_load,
   input  logic [rd_conv_pkg::LANE_ADDR_W-1:0]   lane_addr,
   input  rd_conv_pkg::beat_size_e               beat_size,
   input  logic [rd_conv_pkg::SLV_BYTES*8-1:0]   slave_data,
   output logic [rd_conv_pkg::MST_BYTES*8-1:0]   master_data
);

   logic [rd_conv_pkg::MST_BYTES*8-1:0] pack_q;
   logic [rd_conv_pkg::MST_BYTES*8-1:0] pack_next;
   logic [rd_conv_pkg::LANE_ADDR_W:0]   lane_end;

   assign lane_end = {1'b0, lane_addr} + ((rd_conv_pkg::LANE_ADDR_W + 1)'(1) << beat_size);

   // Slave lane is master lane mod 4 since beats are aligned
   always_comb
   begin
      pack_next = pack_q;
      for (int i = 0; i < rd_conv_pkg::MST_BYTES; i++)
      begin
         if ((i >= lane_addr) && (i < lane_end))
         begin
            pack_next[i*8 +: 8] = slave_data[(i % rd_conv_pkg::SLV_BYTES)*8 +: 8];
         end
      end
   end

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         pack_q      <= '0;
         master_data <= '0;
      end
      else
      begin
         if (slave_fire)
         begin
            pack_q <= pack_next;
         end
         // Includes the bytes of the beat that closes the word
         if (master_load)
         begin
            master_data <= pack_next;
         end
      end
   end

endmodule

// File: rd_pack/rd_resp_merge.sv
module rd_resp_merge
(
   input  logic               ACLK,
   input  logic               sysReset,
   input  logic               slave_fire,
   input  logic               master_load,
   input  rd_conv_pkg::resp_e slave_resp,
   output rd_conv_pkg::resp_e master_resp
);

   rd_conv_pkg::resp_e resp_acc;
   rd_conv_pkg::resp_e resp_worst;

   // Numeric order of the codes ranks them
   assign resp_worst = (slave_resp > resp_acc) ? slave_resp : resp_acc;

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         resp_acc    <= rd_conv_pkg::OKAY;
         master_resp <= rd_conv_pkg::OKAY;
      end
      else if (master_load)
      begin
         master_resp <= resp_worst;
         resp_acc    <= rd_conv_pkg::OKAY;
      end
      else if (slave_fire)
      begin
         resp_acc <= resp_worst;
      end
   end

endmodule

// File: src/rd_conv_top.sv
module rd_conv_top
(
   input  logic                   ACLK,
   input  logic                   sysReset,
   input  logic                   cmd_wr,
   input  rd_conv_pkg::rd_cmd_t   cmd,
   output logic                   cmd_full,
   input  logic                   slave_valid,
   input  rd_conv_pkg::slv_beat_t slave_beat,
   output logic                   slave_ready,
   output logic                   master_valid,
   output rd_conv_pkg::mst_beat_t master_beat,
   input  logic                   master_ready
);

   rd_conv_pkg::rd_cmd_t                cmd_head;
   logic                                cmd_empty;
   logic                                cmd_pop;
   logic                                slave_fire;
   logic                                master_load;
   logic                                master_last;
   logic                                first_beat;
   logic [rd_conv_pkg::LANE_ADDR_W-1:0] lane_addr;
   logic                                word_end;
   logic [rd_conv_pkg::MST_BYTES*8-1:0] master_data;
   rd_conv_pkg::resp_e                  master_resp;

   rd_cmd_fifo u_cmd_fifo
   (
      .ACLK      (ACLK),
      .sysReset  (sysReset),
      .cmd_wr    (cmd_wr),
      .cmd_in    (cmd),
      .cmd_pop   (cmd_pop),
      .cmd_head  (cmd_head),
      .cmd_empty (cmd_empty),
      .cmd_full  (cmd_full)
   );

   rd_pack_ctrl u_pack_ctrl
   (
      .ACLK         (ACLK),
      .sysReset     (sysReset),
      .cmd_empty    (cmd_empty),
      .slave_valid  (slave_valid),
      .slave_last   (slave_beat.last),
      .word_end     (word_end),
      .master_ready (master_ready),
      .slave_ready  (slave_ready),
      .slave_fire   (slave_fire),
      .cmd_pop      (cmd_pop),
      .master_load  (master_load),
      .master_valid (master_valid),
      .master_last  (master_last),
      .first_beat   (first_beat)
   );

   rd_lane_pos u_lane_pos
   (
      .ACLK       (ACLK),
      .sysReset   (sysReset),
      .cmd_head   (cmd_head),
      .first_beat (first_beat),
      .slave_fire (slave_fire),
      .lane_addr  (lane_addr),
      .word_end   (word_end)
   );

   rd_data_pack u_data_pack
   (
      .ACLK        (ACLK),
      .sysReset    (sysReset),
      .slave_fire  (slave_fire),
      .master_load (master_load),
      .lane_addr   (lane_addr),
      .beat_size   (cmd_head.size),
      .slave_data  (slave_beat.data),
      .master_data (master_data)
   );

   rd_resp_merge u_resp_merge
   (
      .ACLK        (ACLK),
      .sysReset    (sysReset),
      .slave_fire  (slave_fire),
      .master_load (master_load),
      .slave_resp  (slave_beat.resp),
      .master_resp (master_resp)
   );

   assign master_beat = '{data: master_data, resp: master_resp, last: master_last};

endmodule

// File: tb/tb_rd_conv_checker.sv
module tb_rd_conv_checker
(
   input  logic                   ACLK,
   input  logic                   sysReset,
   input  logic                   cmd_wr,
   input  rd_conv_pkg::rd_cmd_t   cmd,
   input  logic                   cmd_full,
   input  logic                   slave_valid,
   input  rd_conv_pkg::slv_beat_t slave_beat,
   input  logic                   slave_ready,
   input  logic                   master_valid,
   input  rd_conv_pkg::mst_beat_t master_beat,
   input  logic                   master_ready,
   output logic                   check_error,
   output int                     pending
);

   timeunit 1ns;
   timeprecision 1ps;

   rd_conv_pkg::rd_cmd_t   cmd_q [$];
   rd_conv_pkg::mst_beat_t exp_q [$];
   logic [rd_conv_pkg::MST_BYTES*8-1:0] model_data;
   rd_conv_pkg::resp_e     model_resp;
   int                     model_addr;
   bit                     model_first;
   int                     queued;

   initial
   begin
      check_error = 1'b0;
      pending     = 0;
      queued      = 0;
   end

   task automatic flag_error(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      check_error = 1'b1;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model of the packing rules
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge ACLK or negedge sysReset)
   begin : model
      rd_conv_pkg::rd_cmd_t   c;
      rd_conv_pkg::mst_beat_t exp;
      int                     nbytes;
      int                     addr;
      if (!sysReset)
      begin
         cmd_q.delete();
         exp_q.delete();
         model_data  = '0;
         model_resp  = rd_conv_pkg::OKAY;
         model_addr  = 0;
         model_first = 1'b1;
      end
      else
      begin
         if (master_valid && master_ready)
         begin
            a_beat_expected : assert (exp_q.size() != 0)
               else flag_error("master beat delivered with none expected");
            if (exp_q.size() != 0)
            begin
               exp = exp_q.pop_front();
               a_beat_match : assert (master_beat == exp)
                  else flag_error($sformatf(
                     "master beat got %h/%0d/%0b, expected %h/%0d/%0b",
                     master_beat.data, master_beat.resp, master_beat.last,
                     exp.data, exp.resp, exp.last));
            end
         end
         if (slave_valid && slave_ready)
         begin
            a_cmd_present : assert (cmd_q.size() != 0)
               else flag_error("slave beat accepted with no command queued");
            if (cmd_q.size() != 0)
            begin
               c      = cmd_q[0];
               nbytes = 1 << c.size;
               // First beat starts at the command address aligned to the size
               addr   = model_first ? (c.start_addr & ~(nbytes - 1)) : model_addr;
               for (int i = 0; i < nbytes; i++)
               begin
                  model_data[(addr + i)*8 +: 8] = slave_beat.data[((addr + i) % 4)*8 +: 8];
               end
               if (slave_beat.resp > model_resp)
               begin
                  model_resp = slave_beat.resp;
               end
               if ((addr + nbytes >= rd_conv_pkg::MST_BYTES) || slave_beat.last)
               begin
                  exp.data   = model_data;
                  exp.resp   = model_resp;
                  exp.last   = slave_beat.last;
                  exp_q.push_back(exp);
                  model_resp = rd_conv_pkg::OKAY;
               end
               model_addr  = (addr + nbytes) % rd_conv_pkg::MST_BYTES;
               model_first = slave_beat.last;
               if (slave_beat.last)
               begin
                  c = cmd_q.pop_front();
               end
            end
         end
         // A write shows up at the queue head one cycle later
         if (cmd_wr)
         begin
            cmd_q.push_back(cmd);
         end
      end
      queued  = cmd_q.size();
      pending = exp_q.size();
   end

   ////////////////////////////////////////////////////////////////////////////
   // Handshake rules
   ////////////////////////////////////////////////////////////////////////////

   a_idle_after_reset : assert property (
      @(posedge ACLK) $rose(sysReset) |-> (!master_valid && !slave_ready && !cmd_full)
   ) else flag_error("outputs not idle after reset");

   a_no_cmd_no_ready : assert property (
      @(posedge ACLK) disable iff (!sysReset)
      (queued == 0) |-> !slave_ready
   ) else flag_error("slave_ready high with no command queued");

   a_full_level : assert property (
      @(posedge ACLK) disable iff (!sysReset)
      1'b1 |-> (cmd_full == (queued == rd_conv_pkg::CMD_DEPTH))
   ) else flag_error("cmd_full does not match the number of queued commands");

   a_hold_no_ready : assert property (
      @(posedge ACLK) disable iff (!sysReset)
      (master_valid && !master_ready) |-> !slave_ready
   ) else flag_error("slave_ready high while master holds a beat");

   a_hold_stable : assert property (
      @(posedge ACLK) disable iff (!sysReset)
      (master_valid && !master_ready) |=> (master_valid && $stable(master_beat))
   ) else flag_error("master beat changed while held");

   a_last_latency : assert property (
      @(posedge ACLK) disable iff (!sysReset)
      (slave_valid && slave_ready && slave_beat.last) |=> (master_valid && master_beat.last)
   ) else flag_error("last master beat not issued one cycle after last slave beat");

endmodule

// File: tb/tb_rd_conv.sv
module tb_rd_conv;

   timeunit 1ns;
   timeprecision 1ps;

   // About 41 commands of at most 14 beats with stalls stay far below this
   localparam int TIMEOUT_CYCLES = 5000;

   logic                   ACLK;
   logic                   sysReset;
   logic                   cmd_wr;
   rd_conv_pkg::rd_cmd_t   cmd;
   logic                   cmd_full;
   logic                   slave_valid;
   rd_conv_pkg::slv_beat_t slave_beat;
   logic                   slave_ready;
   logic                   master_valid;
   rd_conv_pkg::mst_beat_t master_beat;
   logic                   master_ready;
   logic                   check_error;
   int                     pending;
   int                     cycle_count = 0;
   int                     stall_pct   = 0;
   bit                     stall_hold  = 1'b0;

   rd_conv_top u_dut
   (
      .ACLK         (ACLK),
      .sysReset     (sysReset),
      .cmd_wr       (cmd_wr),
      .cmd          (cmd),
      .cmd_full     (cmd_full),
      .slave_valid  (slave_valid),
      .slave_beat   (slave_beat),
      .slave_ready  (slave_ready),
      .master_valid (master_valid),
      .master_beat  (master_beat),
      .master_ready (master_ready)
   );

   tb_rd_conv_checker u_checker
   (
      .ACLK         (ACLK),
      .sysReset     (sysReset),
      .cmd_wr       (cmd_wr),
      .cmd          (cmd),
      .cmd_full     (cmd_full),
      .slave_valid  (slave_valid),
      .slave_beat   (slave_beat),
      .slave_ready  (slave_ready),
      .master_valid (master_valid),
      .master_beat  (master_beat),
      .master_ready (master_ready),
      .check_error  (check_error),
      .pending      (pending)
   );

   initial
   begin
      ACLK = 1'b0;
   end

   always #4 ACLK = ~ACLK;

   // Random or scripted stalls on the master side
   always @(posedge ACLK)
   begin
      if (stall_hold)
      begin
         master_ready <= 1'b0;
      end
      else if (stall_pct == 0)
      begin
         master_ready <= 1'b1;
      end
      else
      begin
         master_ready <= ($urandom_range(99) >= stall_pct);
      end
   end

   always @(posedge ACLK)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("ERRORS FOUND");
         $fatal(1, "run stopped by timeout");
      end
   end

   always @(posedge check_error)
   begin
      $display("ERRORS FOUND");
      $fatal(1, "run stopped at first failed check");
   end

   ////////////////////////////////////////////////////////////////////////////
   // Command writer and slave driver
   ////////////////////////////////////////////////////////////////////////////

   task automatic push_cmd(input logic [3:0] addr, input rd_conv_pkg::beat_size_e size);
      while (cmd_full)
      begin
         @(posedge ACLK);
      end
      cmd_wr <= 1'b1;
      cmd    <= '{start_addr: addr, size: size};
      @(posedge ACLK);
      cmd_wr <= 1'b0;
      @(posedge ACLK);
   endtask

   task automatic send_burst(input int nbeats, input int decerr_at, input bit rand_resp);
      rd_conv_pkg::slv_beat_t b;
      for (int i = 0; i < nbeats; i++)
      begin
         b.data = $urandom();
         if (i == decerr_at)
         begin
            b.resp = rd_conv_pkg::DECERR;
         end
         else if (rand_resp)
         begin
            b.resp = rd_conv_pkg::resp_e'($urandom_range(3));
         end
         else
         begin
            b.resp = rd_conv_pkg::OKAY;
         end
         b.last      = (i == nbeats - 1);
         slave_valid <= 1'b1;
         slave_beat  <= b;
         do
         begin
            @(posedge ACLK);
         end
         while (!slave_ready);
         if ($urandom_range(3) == 0)
         begin
            slave_valid <= 1'b0;
            @(posedge ACLK);
         end
      end
      slave_valid <= 1'b0;
   endtask

   task automatic run_cmd(input logic [3:0] addr, input rd_conv_pkg::beat_size_e size,
                          input int nbeats, input int decerr_at, input bit rand_resp);
      push_cmd(addr, size);
      send_burst(nbeats, decerr_at, rand_resp);
   endtask

   initial
   begin : stimulus
      int                      n;
      rd_conv_pkg::beat_size_e sz;
      void'($urandom(32'hb944));
      sysReset     = 1'b0;
      cmd_wr       = 1'b0;
      cmd          = '0;
      slave_valid  = 1'b0;
      slave_beat   = '0;
      master_ready = 1'b1;
      repeat (2) @(posedge ACLK);
      sysReset <= 1'b1;
      @(posedge ACLK);

      // Slave offers a beat with the queue empty
      slave_valid <= 1'b1;
      slave_beat  <= '{data: 32'hdead_beef, resp: rd_conv_pkg::OKAY, last: 1'b1};
      repeat (4) @(posedge ACLK);
      slave_valid <= 1'b0;

      run_cmd(4'd0, rd_conv_pkg::SIZE_4B, 4, -1, 1'b0);

      // Narrow unaligned bursts wrapping past lane 15
      run_cmd(4'd5, rd_conv_pkg::SIZE_1B, 14, -1, 1'b0);
      run_cmd(4'd3, rd_conv_pkg::SIZE_2B, 11, -1, 1'b0);
      run_cmd(4'd9, rd_conv_pkg::SIZE_1B, 3, -1, 1'b0);

      // DECERR in mid-word, then OKAYs
      run_cmd(4'd0, rd_conv_pkg::SIZE_4B, 4, 1, 1'b0);
      run_cmd(4'd4, rd_conv_pkg::SIZE_2B, 8, 2, 1'b0);

      // Fill the command queue, then drain it
      push_cmd(4'd2, rd_conv_pkg::SIZE_1B);
      push_cmd(4'd6, rd_conv_pkg::SIZE_2B);
      push_cmd(4'd8, rd_conv_pkg::SIZE_4B);
      push_cmd(4'd15, rd_conv_pkg::SIZE_1B);
      send_burst(5, -1, 1'b1);
      send_burst(9, -1, 1'b1);
      send_burst(3, -1, 1'b1);
      send_burst(2, -1, 1'b1);

      // Master holds a loaded beat
      stall_hold <= 1'b1;
      fork
         run_cmd(4'd0, rd_conv_pkg::SIZE_4B, 8, -1, 1'b1);
         begin
            repeat (12) @(posedge ACLK);
            stall_hold <= 1'b0;
         end
      join

      stall_pct <= 30;
      repeat (30)
      begin
         sz = rd_conv_pkg::beat_size_e'($urandom_range(2));
         n  = $urandom_range(12, 1);
         run_cmd(4'($urandom_range(15)), sz, n, -1, 1'b1);
      end

      stall_pct <= 0;
      repeat (4) @(posedge ACLK);
      while (master_valid)
      begin
         @(posedge ACLK);
      end
      repeat (2) @(posedge ACLK);

      a_all_delivered : assert (pending == 0)
         else $display("CHECK FAILED at %0t ns: %0d expected master beats never arrived",
                       $time, pending);
      if ((pending != 0) || check_error)
      begin
         $display("ERRORS FOUND");
         $fatal(1, "run ended with failed checks");
      end
      else
      begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

// File: filelist.f
common/rd_conv_pkg.sv
src/rd_cmd_fifo.sv
rd_pack/rd_pack_ctrl.sv
rd_pack/rd_lane_pos.sv
rd_pack/rd_data_pack.sv
rd_pack/rd_resp_merge.sv
src/rd_conv_top.sv
tb/tb_rd_conv_checker.sv
tb/tb_rd_conv.sv
